// File: hdl/wisc_pkg.sv
`default_nettype none

package wisc_pkg;

    localparam int DATA_W = 16;

    localparam logic [4:0] OP_HALT  = 5'b00000;
    localparam logic [4:0] OP_NOP   = 5'b00001;
    localparam logic [4:0] OP_SIIC  = 5'b00010;
    localparam logic [4:0] OP_RTI   = 5'b00011;
    localparam logic [4:0] OP_J     = 5'b00100;
    localparam logic [4:0] OP_JR    = 5'b00101;
    localparam logic [4:0] OP_JAL   = 5'b00110;
    localparam logic [4:0] OP_JALR  = 5'b00111;
    localparam logic [4:0] OP_ADDI  = 5'b01000;
    localparam logic [4:0] OP_SUBI  = 5'b01001;
    localparam logic [4:0] OP_XORI  = 5'b01010;
    localparam logic [4:0] OP_ANDNI = 5'b01011;
    localparam logic [4:0] OP_BEQZ  = 5'b01100;
    localparam logic [4:0] OP_BNEZ  = 5'b01101;
    localparam logic [4:0] OP_BLTZ  = 5'b01110;
    localparam logic [4:0] OP_BGEZ  = 5'b01111;
    localparam logic [4:0] OP_ST    = 5'b10000;
    localparam logic [4:0] OP_LD    = 5'b10001;
    localparam logic [4:0] OP_SLBI  = 5'b10010;
    localparam logic [4:0] OP_STU   = 5'b10011;
    localparam logic [4:0] OP_ROLI  = 5'b10100;
    localparam logic [4:0] OP_SLLI  = 5'b10101;
    localparam logic [4:0] OP_RORI  = 5'b10110;
    localparam logic [4:0] OP_SRLI  = 5'b10111;
    localparam logic [4:0] OP_LBI   = 5'b11000;
    localparam logic [4:0] OP_BTR   = 5'b11001;
    localparam logic [4:0] OP_SHIFT = 5'b11010;   // ROL, SLL, ROR, SRL by func
    localparam logic [4:0] OP_ARITH = 5'b11011;   // ADD, SUB, XOR, ANDN by func
    localparam logic [4:0] OP_SEQ   = 5'b11100;
    localparam logic [4:0] OP_SLT   = 5'b11101;
    localparam logic [4:0] OP_SLE   = 5'b11110;
    localparam logic [4:0] OP_SCO   = 5'b11111;

    localparam logic [2:0] SRC_REG2  = 3'd0;
    localparam logic [2:0] SRC_SEXT5 = 3'd1;
    localparam logic [2:0] SRC_ZEXT5 = 3'd2;
    localparam logic [2:0] SRC_SEXT8 = 3'd3;
    localparam logic [2:0] SRC_ZEXT8 = 3'd4;
    localparam logic [2:0] SRC_ZERO  = 3'd5;
    localparam logic [2:0] SRC_NONE  = 3'd7;

    localparam logic [1:0] DST_42  = 2'd0;
    localparam logic [1:0] DST_75  = 2'd1;
    localparam logic [1:0] DST_108 = 2'd2;
    localparam logic [1:0] DST_R7  = 2'd3;

    localparam logic [3:0] ALU_ADD   = 4'd0;
    localparam logic [3:0] ALU_XOR   = 4'd1;
    localparam logic [3:0] ALU_ANDN  = 4'd2;
    localparam logic [3:0] ALU_ROL   = 4'd3;
    localparam logic [3:0] ALU_SLL   = 4'd4;
    localparam logic [3:0] ALU_ROR   = 4'd5;
    localparam logic [3:0] ALU_SRL   = 4'd6;
    localparam logic [3:0] ALU_SEQ   = 4'd7;
    localparam logic [3:0] ALU_SLT   = 4'd8;
    localparam logic [3:0] ALU_SLE   = 4'd9;
    localparam logic [3:0] ALU_SCO   = 4'd10;
    localparam logic [3:0] ALU_BTR   = 4'd11;
    localparam logic [3:0] ALU_PASSB = 4'd12;
    localparam logic [3:0] ALU_SLBI  = 4'd13;

    typedef union packed {
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [2:0] rt;
            logic [2:0] rd;
            logic [1:0] func;
        } r_fmt;
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [2:0] rd;
            logic [4:0] imm5;
        } i1_fmt;
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [7:0] imm8;
        } i2_fmt;
    } instr_t;

endpackage

`default_nettype wire

// File: hdl/ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
    logic [2:0] alu_src;
    logic [1:0] reg_dst;
    logic [3:0] alu_op;
    logic       inv_a;
    logic       inv_b;
    logic       cin;
    logic       reg_write;
    logic       mem_write;
    logic       mem_to_reg;
    logic       halt;
    logic       err;

    modport dec (output alu_src, reg_dst, alu_op, inv_a, inv_b, cin,
                 reg_write, mem_write, mem_to_reg, halt, err);
    modport dp  (input  alu_src, reg_dst, alu_op, inv_a, inv_b, cin,
                 reg_write, mem_write, mem_to_reg, halt, err);
endinterface

`default_nettype wire

// File: hdl/master_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module master_ctrl (
    input  wire logic [4:0] opcode,
    input  wire logic [1:0] func,
    ctrl_if.dec             ctrl
);

    logic       r_grp;
    logic [1:0] var_sel;

    assign r_grp   = (opcode[4:1] == 4'b1101);     // SHIFT and ARITH register forms
    assign var_sel = r_grp ? func : opcode[1:0];   // Immediate forms carry variant in opcode

    always_comb begin
        ctrl.alu_src    = wisc_pkg::SRC_NONE;
        ctrl.reg_dst    = wisc_pkg::DST_75;
        ctrl.alu_op     = wisc_pkg::ALU_ADD;
        ctrl.inv_a      = 1'b0;
        ctrl.inv_b      = 1'b0;
        ctrl.cin        = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.halt       = 1'b0;
        ctrl.err        = 1'b0;
        case (opcode)
            wisc_pkg::OP_HALT: ctrl.halt = 1'b1;
            wisc_pkg::OP_NOP, wisc_pkg::OP_SIIC, wisc_pkg::OP_RTI, wisc_pkg::OP_J,
            wisc_pkg::OP_JR, wisc_pkg::OP_JAL, wisc_pkg::OP_JALR:
                ctrl.reg_dst = wisc_pkg::DST_R7;   // No link value, so no write
            wisc_pkg::OP_BEQZ, wisc_pkg::OP_BNEZ, wisc_pkg::OP_BLTZ, wisc_pkg::OP_BGEZ:
                ctrl.alu_src = wisc_pkg::SRC_ZERO;
            wisc_pkg::OP_ADDI, wisc_pkg::OP_SUBI, wisc_pkg::OP_XORI, wisc_pkg::OP_ANDNI,
            wisc_pkg::OP_ARITH: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = r_grp ? wisc_pkg::DST_42 : wisc_pkg::DST_75;
                if (r_grp)
                    ctrl.alu_src = wisc_pkg::SRC_REG2;
                else
                    ctrl.alu_src = var_sel[1] ? wisc_pkg::SRC_ZEXT5 : wisc_pkg::SRC_SEXT5;
                case (var_sel)
                    2'b00: ctrl.alu_op = wisc_pkg::ALU_ADD;
                    2'b01: begin
                        ctrl.alu_op = wisc_pkg::ALU_ADD;
                        ctrl.inv_a  = 1'b1;             // B minus A
                        ctrl.cin    = 1'b1;
                    end
                    2'b10: ctrl.alu_op = wisc_pkg::ALU_XOR;
                    default: begin
                        ctrl.alu_op = wisc_pkg::ALU_ANDN;
                        ctrl.inv_b  = 1'b1;
                    end
                endcase
            end
            wisc_pkg::OP_ROLI, wisc_pkg::OP_SLLI, wisc_pkg::OP_RORI, wisc_pkg::OP_SRLI,
            wisc_pkg::OP_SHIFT: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = r_grp ? wisc_pkg::DST_42 : wisc_pkg::DST_75;
                ctrl.alu_src   = r_grp ? wisc_pkg::SRC_REG2 : wisc_pkg::SRC_ZEXT5;
                case (var_sel)
                    2'b00:   ctrl.alu_op = wisc_pkg::ALU_ROL;
                    2'b01:   ctrl.alu_op = wisc_pkg::ALU_SLL;
                    2'b10:   ctrl.alu_op = wisc_pkg::ALU_ROR;
                    default: ctrl.alu_op = wisc_pkg::ALU_SRL;
                endcase
            end
            wisc_pkg::OP_ST, wisc_pkg::OP_LD, wisc_pkg::OP_STU: begin
                ctrl.alu_src    = wisc_pkg::SRC_SEXT5;   // Rs plus offset
                ctrl.mem_write  = (opcode != wisc_pkg::OP_LD);
                ctrl.reg_write  = (opcode != wisc_pkg::OP_ST);
                ctrl.mem_to_reg = (opcode == wisc_pkg::OP_LD);
                ctrl.reg_dst    = (opcode == wisc_pkg::OP_STU) ? wisc_pkg::DST_108
                                                               : wisc_pkg::DST_75;
            end
            wisc_pkg::OP_BTR: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = wisc_pkg::DST_42;
                ctrl.alu_op    = wisc_pkg::ALU_BTR;
            end
            wisc_pkg::OP_SEQ, wisc_pkg::OP_SLT, wisc_pkg::OP_SLE, wisc_pkg::OP_SCO: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = wisc_pkg::DST_42;
                ctrl.alu_src   = wisc_pkg::SRC_REG2;
                ctrl.inv_b     = (opcode != wisc_pkg::OP_SCO);   // Rs minus Rt
                ctrl.cin       = (opcode != wisc_pkg::OP_SCO);
                case (opcode[1:0])
                    2'b00:   ctrl.alu_op = wisc_pkg::ALU_SEQ;
                    2'b01:   ctrl.alu_op = wisc_pkg::ALU_SLT;
                    2'b10:   ctrl.alu_op = wisc_pkg::ALU_SLE;
                    default: ctrl.alu_op = wisc_pkg::ALU_SCO;
                endcase
            end
            wisc_pkg::OP_LBI, wisc_pkg::OP_SLBI: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = wisc_pkg::DST_108;
                ctrl.alu_src   = (opcode == wisc_pkg::OP_LBI) ? wisc_pkg::SRC_SEXT8
                                                              : wisc_pkg::SRC_ZEXT8;
                ctrl.alu_op    = (opcode == wisc_pkg::OP_LBI) ? wisc_pkg::ALU_PASSB
                                                              : wisc_pkg::ALU_SLBI;
            end
            default: ctrl.err = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/operand_sel.sv
`timescale 1ns/1ps
`default_nettype none

module operand_sel (
    input  wisc_pkg::instr_t                    instr,
    ctrl_if.dp                                  ctrl,
    input  wire logic [wisc_pkg::DATA_W-1:0]    rt_data,
    output logic      [wisc_pkg::DATA_W-1:0]    op_b,
    output logic      [2:0]                     dst
);

    localparam int W = wisc_pkg::DATA_W;

    logic [4:0] imm5;
    logic [7:0] imm8;

    assign imm5 = instr.i1_fmt.imm5;
    assign imm8 = instr.i2_fmt.imm8;

    always_comb begin
        case (ctrl.alu_src)
            wisc_pkg::SRC_REG2:  op_b = rt_data;
            wisc_pkg::SRC_SEXT5: op_b = {{(W-5){imm5[4]}}, imm5};
            wisc_pkg::SRC_ZEXT5: op_b = {{(W-5){1'b0}}, imm5};
            wisc_pkg::SRC_SEXT8: op_b = {{(W-8){imm8[7]}}, imm8};
            wisc_pkg::SRC_ZEXT8: op_b = {{(W-8){1'b0}}, imm8};
            wisc_pkg::SRC_ZERO:  op_b = '0;
            default:             op_b = '0;   // B unused
        endcase
    end

    always_comb begin
        case (ctrl.reg_dst)
            wisc_pkg::DST_42:  dst = instr.r_fmt.rd;
            wisc_pkg::DST_75:  dst = instr.i1_fmt.rd;
            wisc_pkg::DST_108: dst = instr.i2_fmt.rs;
            default:           dst = 3'd7;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  wire logic [2:0]                   rs_addr,
    input  wire logic [2:0]                   rt_addr,
    output logic      [wisc_pkg::DATA_W-1:0]  rs_data,
    output logic      [wisc_pkg::DATA_W-1:0]  rt_data,
    input  wire logic                         we,
    input  wire logic [2:0]                   wr_addr,
    input  wire logic [wisc_pkg::DATA_W-1:0]  wr_data
);

    logic [wisc_pkg::DATA_W-1:0] regs [8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads see the old value during a write
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    ctrl_if.dp                                ctrl,
    input  wire logic [wisc_pkg::DATA_W-1:0]  op_a,
    input  wire logic [wisc_pkg::DATA_W-1:0]  op_b,
    output logic      [wisc_pkg::DATA_W-1:0]  result
);

    localparam int W = wisc_pkg::DATA_W;

    logic [W-1:0]   a_in;
    logic [W-1:0]   b_in;
    logic [W:0]     sum_full;
    logic [3:0]     shamt;
    logic [2*W-1:0] dbl;
    logic [2*W-1:0] rol_w;
    logic [2*W-1:0] ror_w;
    logic [W-1:0]   rev;
    logic           zero;
    logic           ovf;
    logic           lt;

    assign a_in     = ctrl.inv_a ? ~op_a : op_a;
    assign b_in     = ctrl.inv_b ? ~op_b : op_b;
    assign sum_full = {1'b0, a_in} + {1'b0, b_in} + {{W{1'b0}}, ctrl.cin};

    assign zero = (sum_full[W-1:0] == '0);
    assign ovf  = (a_in[W-1] == b_in[W-1]) && (sum_full[W-1] != a_in[W-1]);
    assign lt   = sum_full[W-1] ^ ovf;   // Signed Rs < Rt

    assign shamt = op_b[3:0];
    assign dbl   = {op_a, op_a};
    assign rol_w = dbl << shamt;
    assign ror_w = dbl >> shamt;

    always_comb begin
        for (int i = 0; i < W; i++)
            rev[i] = op_a[W-1-i];
    end

    always_comb begin
        case (ctrl.alu_op)
            wisc_pkg::ALU_ADD:   result = sum_full[W-1:0];
            wisc_pkg::ALU_XOR:   result = a_in ^ b_in;
            wisc_pkg::ALU_ANDN:  result = a_in & b_in;   // B already inverted
            wisc_pkg::ALU_ROL:   result = rol_w[2*W-1:W];
            wisc_pkg::ALU_SLL:   result = op_a << shamt;
            wisc_pkg::ALU_ROR:   result = ror_w[W-1:0];
            wisc_pkg::ALU_SRL:   result = op_a >> shamt;
            wisc_pkg::ALU_SEQ:   result = {{(W-1){1'b0}}, zero};
            wisc_pkg::ALU_SLT:   result = {{(W-1){1'b0}}, lt};
            wisc_pkg::ALU_SLE:   result = {{(W-1){1'b0}}, lt | zero};
            wisc_pkg::ALU_SCO:   result = {{(W-1){1'b0}}, sum_full[W]};
            wisc_pkg::ALU_BTR:   result = rev;
            wisc_pkg::ALU_PASSB: result = op_b;
            wisc_pkg::ALU_SLBI:  result = (op_a << 8) | op_b;
            default:             result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int MEM_AW = 8
) (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  wire logic                         we,
    input  wire logic [MEM_AW-1:0]            addr,
    input  wire logic [wisc_pkg::DATA_W-1:0]  wdata,
    output logic      [wisc_pkg::DATA_W-1:0]  rdata
);

    localparam int DEPTH = 1 << MEM_AW;

    logic [wisc_pkg::DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= '0;
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];   // Async read for LD

endmodule

`default_nettype wire

// File: hdl/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
    parameter int MEM_AW = 8
) (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  wire logic                         instr_valid,
    input  wire logic [15:0]                  instr,
    output logic                              ret_valid,
    output logic                              ret_we,
    output logic      [2:0]                   ret_dst,
    output logic      [wisc_pkg::DATA_W-1:0]  ret_data,
    output logic                              ret_st,
    output logic                              ret_err,
    output logic                              halted
);

    wisc_pkg::instr_t            ins;
    logic                        accept;
    logic                        reg_we;
    logic                        mem_we;
    logic [2:0]                  rt_addr;
    logic [2:0]                  dst;
    logic [wisc_pkg::DATA_W-1:0] rs_data;
    logic [wisc_pkg::DATA_W-1:0] rt_data;
    logic [wisc_pkg::DATA_W-1:0] op_b;
    logic [wisc_pkg::DATA_W-1:0] alu_result;
    logic [wisc_pkg::DATA_W-1:0] mem_rdata;
    logic [wisc_pkg::DATA_W-1:0] wb_data;

    ctrl_if ctrl_bus ();

    assign ins    = instr;
    assign accept = instr_valid & ~halted;
    assign reg_we = accept & ctrl_bus.reg_write;
    assign mem_we = accept & ctrl_bus.mem_write;

    // Store data Rd shares the Rt field
    assign rt_addr = ins.r_fmt.rt;
    assign wb_data = ctrl_bus.mem_to_reg ? mem_rdata : alu_result;

    master_ctrl u_master_ctrl (
        .opcode (ins.r_fmt.opcode),
        .func   (ins.r_fmt.func),
        .ctrl   (ctrl_bus.dec)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (ins.r_fmt.rs),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      (reg_we),
        .wr_addr (dst),
        .wr_data (wb_data)
    );

    operand_sel u_operand_sel (
        .instr   (ins),
        .ctrl    (ctrl_bus.dp),
        .rt_data (rt_data),
        .op_b    (op_b),
        .dst     (dst)
    );

    alu u_alu (
        .ctrl   (ctrl_bus.dp),
        .op_a   (rs_data),
        .op_b   (op_b),
        .result (alu_result)
    );

    data_mem #(
        .MEM_AW (MEM_AW)
    ) u_data_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (mem_we),
        .addr   (alu_result[MEM_AW-1:0]),
        .wdata  (rt_data),
        .rdata  (mem_rdata)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ret_valid <= 1'b0;
            ret_we    <= 1'b0;
            ret_st    <= 1'b0;
            ret_err   <= 1'b0;
            halted    <= 1'b0;
        end else begin
            ret_valid <= accept;
            ret_we    <= reg_we;
            ret_st    <= mem_we;
            ret_err   <= accept & ctrl_bus.err;
            if (accept && ctrl_bus.halt)
                halted <= 1'b1;   // Sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ret_dst  <= dst;
            ret_data <= wb_data;
        end
    end

endmodule

`default_nettype wire

// File: dv/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
    parameter int MEM_AW = 8
) (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  wire logic                         instr_valid,
    input  wire logic [15:0]                  instr,
    input  wire logic                         ret_valid,
    input  wire logic                         ret_we,
    input  wire logic [2:0]                   ret_dst,
    input  wire logic [wisc_pkg::DATA_W-1:0]  ret_data,
    input  wire logic                         ret_st,
    input  wire logic                         ret_err,
    input  wire logic                         halted,
    output int                                n_checks,
    output int                                n_errors
);

    localparam int W = wisc_pkg::DATA_W;

    logic [W-1:0] regs [8];
    logic [W-1:0] mem [1 << MEM_AW];
    logic         m_halted;
    logic         e_valid;
    logic         e_we;
    logic         e_st;
    logic         e_err;
    logic [2:0]   e_dst;
    logic [W-1:0] e_data;
    logic         clk_seen;

    initial begin
        n_checks = 0;
        n_errors = 0;
        clk_seen = 1'b0;
    end

    function automatic logic [W-1:0] rotate_left(input logic [W-1:0] x, input logic [3:0] n);
        return (x << n) | (x >> (W - int'(n)));
    endfunction

    function automatic logic [W-1:0] rotate_right(input logic [W-1:0] x, input logic [3:0] n);
        return (x >> n) | (x << (W - int'(n)));
    endfunction

    function automatic logic [W-1:0] bit_reverse(input logic [W-1:0] x);
        logic [W-1:0] r;
        for (int i = 0; i < W; i++)
            r[i] = x[W-1-i];
        return r;
    endfunction

    task automatic check_bit(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input logic [W-1:0] got,
                              input logic [W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %0t: %s is 0x%h, expected 0x%h", $time, what, got, exp);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 8; i++)
            regs[i] = '0;
        for (int i = 0; i < (1 << MEM_AW); i++)
            mem[i] = '0;
        m_halted = 1'b0;
        e_valid  = 1'b0;
        e_we     = 1'b0;
        e_st     = 1'b0;
        e_err    = 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] dst, input logic [W-1:0] data);
        e_we   = 1'b1;
        e_dst  = dst;
        e_data = data;
    endtask

    task automatic step_model(input logic [15:0] ins);
        logic [4:0]        op;
        logic [2:0]        rs;
        logic [2:0]        rt;
        logic [2:0]        rd_r;
        logic [W-1:0]      a;
        logic [W-1:0]      b;
        logic [W-1:0]      s5;
        logic [W-1:0]      z5;
        logic [W-1:0]      ea;
        logic [W:0]        sum;
        logic [MEM_AW-1:0] addr;
        op   = ins[15:11];
        rs   = ins[10:8];
        rt   = ins[7:5];   // Also Rd of the I1 format
        rd_r = ins[4:2];
        a    = regs[rs];
        b    = regs[rt];
        s5   = {{(W-5){ins[4]}}, ins[4:0]};
        z5   = {{(W-5){1'b0}}, ins[4:0]};
        ea   = a + s5;
        addr = ea[MEM_AW-1:0];
        sum  = {1'b0, a} + {1'b0, b};
        e_we  = 1'b0;
        e_st  = 1'b0;
        e_err = 1'b0;
        case (op)
            wisc_pkg::OP_HALT:  m_halted = 1'b1;
            wisc_pkg::OP_NOP, wisc_pkg::OP_SIIC, wisc_pkg::OP_RTI, wisc_pkg::OP_J,
            wisc_pkg::OP_JR, wisc_pkg::OP_JAL, wisc_pkg::OP_JALR, wisc_pkg::OP_BEQZ,
            wisc_pkg::OP_BNEZ, wisc_pkg::OP_BLTZ, wisc_pkg::OP_BGEZ:
                e_we = 1'b0;   // Retire without a write
            wisc_pkg::OP_ADDI:  write_reg(rt, a + s5);
            wisc_pkg::OP_SUBI:  write_reg(rt, s5 - a);
            wisc_pkg::OP_XORI:  write_reg(rt, a ^ z5);
            wisc_pkg::OP_ANDNI: write_reg(rt, a & ~z5);
            wisc_pkg::OP_ARITH: begin
                case (ins[1:0])
                    2'b00:   write_reg(rd_r, a + b);
                    2'b01:   write_reg(rd_r, b - a);
                    2'b10:   write_reg(rd_r, a ^ b);
                    default: write_reg(rd_r, a & ~b);
                endcase
            end
            wisc_pkg::OP_ROLI:  write_reg(rt, rotate_left(a, ins[3:0]));
            wisc_pkg::OP_SLLI:  write_reg(rt, a << ins[3:0]);
            wisc_pkg::OP_RORI:  write_reg(rt, rotate_right(a, ins[3:0]));
            wisc_pkg::OP_SRLI:  write_reg(rt, a >> ins[3:0]);
            wisc_pkg::OP_SHIFT: begin
                case (ins[1:0])
                    2'b00:   write_reg(rd_r, rotate_left(a, b[3:0]));
                    2'b01:   write_reg(rd_r, a << b[3:0]);
                    2'b10:   write_reg(rd_r, rotate_right(a, b[3:0]));
                    default: write_reg(rd_r, a >> b[3:0]);
                endcase
            end
            wisc_pkg::OP_ST: begin
                e_st      = 1'b1;
                mem[addr] = b;
            end
            wisc_pkg::OP_STU: begin
                e_st      = 1'b1;
                mem[addr] = b;
                write_reg(rs, ea);
            end
            wisc_pkg::OP_LD:    write_reg(rt, mem[addr]);
            wisc_pkg::OP_LBI:   write_reg(rs, {{(W-8){ins[7]}}, ins[7:0]});
            wisc_pkg::OP_SLBI:  write_reg(rs, (a << 8) | {{(W-8){1'b0}}, ins[7:0]});
            wisc_pkg::OP_BTR:   write_reg(rd_r, bit_reverse(a));
            wisc_pkg::OP_SEQ:   write_reg(rd_r, {{(W-1){1'b0}}, a == b});
            wisc_pkg::OP_SLT:   write_reg(rd_r, {{(W-1){1'b0}}, $signed(a) < $signed(b)});
            wisc_pkg::OP_SLE:   write_reg(rd_r, {{(W-1){1'b0}}, $signed(a) <= $signed(b)});
            wisc_pkg::OP_SCO:   write_reg(rd_r, {{(W-1){1'b0}}, sum[W]});
            default:            e_err = 1'b1;
        endcase
        if (e_we)
            regs[e_dst] = e_data;
    endtask

    // Outputs are taken just before the edge updates them
    always @(posedge clk) begin
        if (!arst_n) begin
            if (clk_seen) begin
                check_bit("ret_valid in reset", ret_valid, 1'b0);
                check_bit("ret_we in reset", ret_we, 1'b0);
                check_bit("ret_st in reset", ret_st, 1'b0);
                check_bit("ret_err in reset", ret_err, 1'b0);
                check_bit("halted in reset", halted, 1'b0);
            end
            reset_model();
        end else begin
            check_bit("ret_valid", ret_valid, e_valid);
            check_bit("ret_we", ret_we, e_we);
            check_bit("ret_st", ret_st, e_st);
            check_bit("ret_err", ret_err, e_err);
            check_bit("halted", halted, m_halted);
            if (e_we) begin
                check_word("ret_dst", {{(W-3){1'b0}}, ret_dst}, {{(W-3){1'b0}}, e_dst});
                check_word("ret_data", ret_data, e_data);
            end
            e_valid = instr_valid && !m_halted;
            if (e_valid) begin
                step_model(instr);
            end else begin
                e_we  = 1'b0;
                e_st  = 1'b0;
                e_err = 1'b0;
            end
        end
        clk_seen = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int MEM_AW     = 8;
    localparam int N_INSTR    = 3000;
    localparam int N_PHASES   = 2;
    localparam int RST_CYCLES = 5;
    localparam int HALT_AT    = N_INSTR - 40;   // Rest of the phase arrives while halted
    // One idle slot per nine instructions on average, plus reset and drain
    localparam int PHASE_CYCLES = RST_CYCLES + N_INSTR * 10 / 9 + 4;
    localparam int MAX_CYCLES   = 2 * N_PHASES * PHASE_CYCLES;

    logic                        clk = 1'b0;
    logic                        arst_n;
    logic                        instr_valid;
    logic [15:0]                 instr;
    logic                        ret_valid;
    logic                        ret_we;
    logic [2:0]                  ret_dst;
    logic [wisc_pkg::DATA_W-1:0] ret_data;
    logic                        ret_st;
    logic                        ret_err;
    logic                        halted;
    logic [31:0]                 rng;
    int                          cycles = 0;
    int                          n_checks;
    int                          n_errors;

    exec_core #(
        .MEM_AW (MEM_AW)
    ) UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ret_valid   (ret_valid),
        .ret_we      (ret_we),
        .ret_dst     (ret_dst),
        .ret_data    (ret_data),
        .ret_st      (ret_st),
        .ret_err     (ret_err),
        .halted      (halted)
    );

    core_checker #(
        .MEM_AW (MEM_AW)
    ) u_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ret_valid   (ret_valid),
        .ret_we      (ret_we),
        .ret_dst     (ret_dst),
        .ret_data    (ret_data),
        .ret_st      (ret_st),
        .ret_err     (ret_err),
        .halted      (halted),
        .n_checks    (n_checks),
        .n_errors    (n_errors)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic apply_reset();
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic run_phase();
        int         issued;
        logic [4:0] op;
        issued = 0;
        while (issued < N_INSTR) begin
            @(negedge clk);
            rng = next_random(rng);
            if (rng % 10 == 0) begin
                instr_valid = 1'b0;
                instr       = rng[15:0];   // Ignored by the DUT
            end else begin
                op = rng[20:16];
                if (issued == HALT_AT)
                    op = wisc_pkg::OP_HALT;
                else if (op == wisc_pkg::OP_HALT)
                    op = wisc_pkg::OP_NOP;
                instr_valid = 1'b1;
                instr       = {op, rng[10:0]};
                issued++;
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;
        repeat (2) @(negedge clk);   // Let the last retirement be checked
    endtask

    initial begin
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rng         = 32'hd0c6e7e5;
        for (int p = 0; p < N_PHASES; p++) begin
            apply_reset();
            run_phase();
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0 && n_checks > 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/wisc_pkg.sv
hdl/ctrl_if.sv
hdl/master_ctrl.sv
hdl/operand_sel.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/exec_core.sv
dv/core_checker.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_top -f src.f --Mdir obj_dir -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -q "^Everything OK$"; then
    exit 0
else
    exit 1
fi
